// File: build.f
source/accel_pkg.sv
source/exec_if.sv
source/glb_ctrl.sv
source/operand_buf.sv
source/bp_mac_core.sv
source/bs_mac_core.sv
source/wb_unit.sv
source/accel_top.sv
test/tb_clk_gen.sv
test/accel_props.sv
test/accel_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module accel_tb -f build.f

run: compile
	./obj_dir/Vaccel_tb > $(LOG) 2>&1 || echo "simulation aborted" >> $(LOG)
	@cat $(LOG)
	@! grep -q "TEST FAIL" $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/accel_tb.sv
`timescale 1ns/1ps

module accel_tb;
    import accel_pkg::*;

    localparam int    N_ROWS     = 4;
    localparam int    MAX_LEN    = 16;
    localparam int    N_B2B      = 4;                 // instructions in the back-to-back test.
    localparam int    T4_LEN     = 9;
    localparam int    CH_INSTR   = 0;
    localparam int    CH_ACT     = 1;
    localparam int    CH_WGT     = 2;
    localparam word_t INSTR_JUNK = 32'h5A5A_0AF0;     // bits the tile must ignore.

    logic        clk;
    logic        rst_n;
    logic        i_instr_valid;
    logic        o_instr_ready;
    instr_t      i_instr_data;
    logic        i_act_valid;
    logic        o_act_ready;
    word_t       i_act_data;
    logic        i_wgt_valid;
    logic        o_wgt_ready;
    word_t       i_wgt_data;
    logic        o_out_valid;
    logic        i_out_ready;
    word_t       o_out_data;
    logic        o_out_last;

    word_t       act_v [MAX_LEN];
    word_t       wgt_v [N_ROWS * MAX_LEN];            // row-major as in the tile.
    acc_t        exp_q [$];
    acc_t        exp_sum;
    logic [31:0] lfsr_q     = 32'ha1af;
    logic [31:0] rdy_lfsr_q = 32'ha1af;
    logic        ready_rand = 1'b0;
    logic        busy       = 1'b0;
    string       cur_test   = "reset";
    int          b2b_len [N_B2B];
    int          beat_idx     = 0;
    int          beats_seen   = 0;
    int          beats_target = 0;
    int          err_cnt      = 0;
    int          err_base     = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    accel_top #(.N_ROWS(N_ROWS), .MAX_LEN(MAX_LEN)) u_accel_top (.*);

    // ****************************************************************
    // random source and reference model
    // ****************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic acc_t ref_row_sum(input int row, input int len);
        int sum;
        int a;
        int b;
        sum = 0;
        for (int w = 0; w < len; w++) begin
            for (int l = 0; l < LANES; l++) begin
                a   = elem_t'(act_v[w][8*l +: 8]);
                b   = elem_t'(wgt_v[row*len + w][8*l +: 8]);
                sum = sum + a * b;
            end
        end
        return sum;
    endfunction

    function automatic int cycle_budget(input int len);
        return 8*len*N_ROWS + 4*len*(N_ROWS + 1) + 4*N_ROWS + 20;
    endfunction

    // ****************************************************************
    // stimulus helpers that enter and leave on a falling edge
    // ****************************************************************
    function automatic logic ready_of(input int chan);
        case (chan)
            CH_INSTR: return o_instr_ready;
            CH_ACT:   return o_act_ready;
            default:  return o_wgt_ready;
        endcase
    endfunction

    task automatic send_beat(input int chan, input word_t data, input logic gaps);
        logic [31:0] gap;
        gap = '0;
        if (gaps) begin
            draw_bits(1, gap);
        end
        if (gap[0]) begin
            @(negedge clk);                           // one idle cycle on the stream.
        end
        case (chan)
            CH_INSTR: i_instr_data = data;
            CH_ACT:   i_act_data = data;
            default:  i_wgt_data = data;
        endcase
        i_instr_valid = (chan == CH_INSTR);
        i_act_valid   = (chan == CH_ACT);
        i_wgt_valid   = (chan == CH_WGT);
        @(posedge clk);
        while (!ready_of(chan)) begin
            @(posedge clk);
        end
        @(negedge clk);
        i_instr_valid = 1'b0;
        i_act_valid   = 1'b0;
        i_wgt_valid   = 1'b0;
    endtask

    task automatic send_instr(input int len, input logic sel, input logic gaps);
        word_t instr;
        for (int r = 0; r < N_ROWS; r++) begin
            exp_q.push_back(ref_row_sum(r, len));
        end
        beats_target = beats_target + N_ROWS;
        instr        = INSTR_JUNK;
        instr[3:0]   = 4'(len - 1);
        instr[8]     = sel;
        send_beat(CH_INSTR, instr, 1'b0);
        for (int w = 0; w < len; w++) begin
            send_beat(CH_ACT, act_v[w], gaps);
        end
        for (int i = 0; i < N_ROWS * len; i++) begin
            send_beat(CH_WGT, wgt_v[i], gaps);
        end
    endtask

    task automatic fill_random(input int len);
        logic [31:0] bits;
        for (int w = 0; w < len; w++) begin
            draw_bits(32, bits);
            act_v[w] = bits;
        end
        for (int i = 0; i < N_ROWS * len; i++) begin
            draw_bits(32, bits);
            wgt_v[i] = bits;
        end
        act_v[0][7:0]                = 8'h80;         // most negative int8 on both sides.
        wgt_v[0][7:0]                = 8'h80;
        wgt_v[N_ROWS*len - 1][31:24] = 8'h80;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = err_cnt;
    endtask

    task automatic finish_test();
        while (beats_seen < beats_target) begin
            @(negedge clk);
        end
        tests_run++;
        if (err_cnt == err_base) begin
            $display("%-16s ok, %0d beats so far", cur_test, beats_seen);
        end else begin
            tests_failed++;
            $display("%-16s failed with %0d errors", cur_test, err_cnt - err_base);
        end
    endtask

    // ****************************************************************
    // output ready, compare process and timeout
    // ****************************************************************
    always @(negedge clk) begin
        if (ready_rand) begin
            rdy_lfsr_q  = lfsr_next(rdy_lfsr_q);
            i_out_ready = rdy_lfsr_q[0];
        end else begin
            i_out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (busy) begin
                assert (!o_instr_ready) else begin
                    $display("%s: instruction ready rose before the final beat", cur_test);
                    err_cnt++;
                end
            end
            if (i_instr_valid && o_instr_ready) begin
                busy = 1'b1;
            end
            if (o_out_valid && i_out_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("%s: output beat arrived with no result pending", cur_test);
                    err_cnt++;
                end
                if (exp_q.size() > 0) begin
                    exp_sum = exp_q.pop_front();
                    assert (o_out_data == exp_sum) else begin
                        $display("[FAIL] %s: row %0d expected %0d, actual %0d",
                                 cur_test, beat_idx, exp_sum, $signed(o_out_data));
                        err_cnt++;
                    end
                    assert (o_out_last == (beat_idx == N_ROWS - 1)) else begin
                        $display("[FAIL] %s: last flag on beat %0d expected %0b, actual %0b",
                                 cur_test, beat_idx, beat_idx == N_ROWS - 1, o_out_last);
                        err_cnt++;
                    end
                end
                if (beat_idx == N_ROWS - 1) begin
                    busy = 1'b0;
                end
                beat_idx = (beat_idx == N_ROWS - 1) ? 0 : beat_idx + 1;
                beats_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles in %s, results stopped arriving",
                     cycle_cnt, cur_test);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ****************************************************************
    // test sequence
    // ****************************************************************
    initial begin
        logic [31:0] bits;
        int          budget;
        i_instr_valid = 1'b0;
        i_instr_data  = '0;
        i_act_valid   = 1'b0;
        i_act_data    = '0;
        i_wgt_valid   = 1'b0;
        i_wgt_data    = '0;
        i_out_ready   = 1'b1;
        for (int k = 0; k < N_B2B; k++) begin
            draw_bits(4, bits);
            b2b_len[k] = int'(bits) + 1;
        end
        budget = cycle_budget(1) + 2 * cycle_budget(16) + cycle_budget(T4_LEN);
        for (int k = 0; k < N_B2B; k++) begin
            budget = budget + cycle_budget(b2b_len[k]);
        end
        cycle_limit = 2 * budget;
        wait (rst_n);
        @(negedge clk);

        begin_test("bp_len1");
        assert (o_instr_ready && !o_act_ready && !o_wgt_ready && !o_out_valid && !o_out_last)
        else begin
            $display("%s: output ports not at their reset values", cur_test);
            err_cnt++;
        end
        act_v[0] = 32'h04FD_0201;
        wgt_v[0] = 32'h0102_0304;
        wgt_v[1] = 32'hFFFE_FDFC;
        wgt_v[2] = 32'h0500_F902;
        wgt_v[3] = 32'h807F_01FF;
        send_instr(1, 1'b0, 1'b0);
        finish_test();

        begin_test("bp_len16_rand");
        fill_random(16);
        send_instr(16, 1'b0, 1'b0);
        finish_test();

        begin_test("bs_len16_rand");
        send_instr(16, 1'b1, 1'b0);                   // same operands as the previous test.
        finish_test();

        begin_test("gaps_backpress");
        fill_random(T4_LEN);
        ready_rand = 1'b1;
        send_instr(T4_LEN, 1'b0, 1'b1);
        finish_test();
        ready_rand = 1'b0;

        begin_test("back_to_back");
        for (int k = 0; k < N_B2B; k++) begin
            fill_random(b2b_len[k]);
            send_instr(b2b_len[k], k[0], 1'b0);       // next instruction waits while this runs.
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, check errors %0d, property failures %0d",
                 tests_run, tests_failed, err_cnt, u_accel_top.u_accel_props.fail_cnt);
        if (err_cnt == 0 && u_accel_top.u_accel_props.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: test/accel_props.sv
`timescale 1ns/1ps

module accel_props (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_instr_ready,
    input  logic               i_act_ready,
    input  logic               i_wgt_ready,
    input  logic               i_out_valid,
    input  logic               i_out_ready,
    input  accel_pkg::word_t   i_out_data,
    input  logic               i_out_last
);

    int fail_cnt = 0;

    // ****************************************************************
    // load phases
    // ****************************************************************
    a_load_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_act_ready && i_wgt_ready))
        else begin
            $error("activation and weight ready are high together");
            fail_cnt++;
        end

    a_busy_no_instr: assert property (@(posedge clk) disable iff (!rst_n)
        (i_act_ready || i_wgt_ready) |-> !i_instr_ready)
        else begin
            $error("instruction ready is high during a load phase");
            fail_cnt++;
        end

    // ****************************************************************
    // output stream
    // ****************************************************************
    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_last |-> i_out_valid)
        else begin
            $error("last flag without a valid beat");
            fail_cnt++;
        end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_out_valid && !i_out_ready) |=> ($stable(i_out_data) && $stable(i_out_last)))
        else begin
            $error("output beat changed under back-pressure");
            fail_cnt++;
        end

endmodule

bind accel_top accel_props u_accel_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_instr_ready (o_instr_ready),
    .i_act_ready   (o_act_ready),
    .i_wgt_ready   (o_wgt_ready),
    .i_out_valid   (o_out_valid),
    .i_out_ready   (i_out_ready),
    .i_out_data    (o_out_data),
    .i_out_last    (o_out_last)
);

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);                               // release away from the sampling edge.
        rst_n = 1'b1;
    end

endmodule

// File: source/accel_top.sv
`timescale 1ns/1ps

module accel_top #(
    parameter  int N_ROWS  = 4,
    parameter  int MAX_LEN = 16,
    localparam int ACT_AW  = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
    localparam int WGT_AW  = (N_ROWS * MAX_LEN > 1) ? $clog2(N_ROWS * MAX_LEN) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_instr_valid,
    output logic                 o_instr_ready,
    input  accel_pkg::instr_t    i_instr_data,
    input  logic                 i_act_valid,
    output logic                 o_act_ready,
    input  accel_pkg::word_t     i_act_data,
    input  logic                 i_wgt_valid,
    output logic                 o_wgt_ready,
    input  accel_pkg::word_t     i_wgt_data,
    output logic                 o_out_valid,
    input  logic                 i_out_ready,
    output accel_pkg::word_t     o_out_data,
    output logic                 o_out_last
);
    import accel_pkg::*;

    logic               act_we;
    logic               wgt_we;
    logic [WGT_AW-1:0]  ld_addr;
    logic [ACT_AW-1:0]  ex_act_addr;
    logic [WGT_AW-1:0]  ex_wgt_addr;
    logic               wb_done;
    acc_t               bp_sum;
    logic               bp_sum_valid;
    acc_t               bs_sum;
    logic               bs_sum_valid;

    exec_if u_exec_if ();

    glb_ctrl #(.N_ROWS(N_ROWS), .MAX_LEN(MAX_LEN)) u_glb_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_instr_valid  (i_instr_valid),
        .o_instr_ready  (o_instr_ready),
        .i_instr_data   (i_instr_data),
        .i_act_valid    (i_act_valid),
        .o_act_ready    (o_act_ready),
        .i_wgt_valid    (i_wgt_valid),
        .o_wgt_ready    (o_wgt_ready),
        .o_act_we       (act_we),
        .o_wgt_we       (wgt_we),
        .o_ld_addr      (ld_addr),
        .o_ex_act_addr  (ex_act_addr),
        .o_ex_wgt_addr  (ex_wgt_addr),
        .i_wb_done      (wb_done),
        .ex             (u_exec_if)
    );

    operand_buf #(.N_ROWS(N_ROWS), .MAX_LEN(MAX_LEN)) u_operand_buf (
        .clk            (clk),
        .i_act_we       (act_we),
        .i_wgt_we       (wgt_we),
        .i_ld_addr      (ld_addr),
        .i_act_data     (i_act_data),
        .i_wgt_data     (i_wgt_data),
        .i_ex_act_addr  (ex_act_addr),
        .i_ex_wgt_addr  (ex_wgt_addr),
        .ex             (u_exec_if)
    );

    bp_mac_core u_bp_mac_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex             (u_exec_if),
        .o_sum          (bp_sum),
        .o_sum_valid    (bp_sum_valid)
    );

    bs_mac_core u_bs_mac_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex             (u_exec_if),
        .o_sum          (bs_sum),
        .o_sum_valid    (bs_sum_valid)
    );

    wb_unit #(.N_ROWS(N_ROWS)) u_wb_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_bp_sum       (bp_sum),
        .i_bp_sum_valid (bp_sum_valid),
        .i_bs_sum       (bs_sum),
        .i_bs_sum_valid (bs_sum_valid),
        .o_out_valid    (o_out_valid),
        .i_out_ready    (i_out_ready),
        .o_out_data     (o_out_data),
        .o_out_last     (o_out_last),
        .o_wb_done      (wb_done)
    );

endmodule

// File: source/wb_unit.sv
`timescale 1ns/1ps

module wb_unit #(
    parameter  int N_ROWS = 4,
    localparam int ROW_AW = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
    localparam int CNT_W  = $clog2(N_ROWS + 1)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  accel_pkg::acc_t    i_bp_sum,
    input  logic               i_bp_sum_valid,
    input  accel_pkg::acc_t    i_bs_sum,
    input  logic               i_bs_sum_valid,
    output logic               o_out_valid,
    input  logic               i_out_ready,
    output accel_pkg::word_t   o_out_data,
    output logic               o_out_last,
    output logic               o_wb_done
);
    import accel_pkg::*;

    acc_t               res_mem [N_ROWS];
    logic [CNT_W-1:0]   wr_cnt_q;                     // rows collected so far.
    logic [ROW_AW-1:0]  rd_ptr_q;
    acc_t               wr_sum;
    logic               wr_en;
    logic               buf_full;
    logic               out_fire;

    assign wr_sum   = i_bs_sum_valid ? i_bs_sum : i_bp_sum;
    assign buf_full = (wr_cnt_q == CNT_W'(N_ROWS));
    assign wr_en    = (i_bp_sum_valid | i_bs_sum_valid) & ~buf_full;
    assign out_fire = o_out_valid & i_out_ready;

    assign o_out_data = res_mem[rd_ptr_q];            // pointer holds under back-pressure.
    assign o_out_last = o_out_valid & (rd_ptr_q == ROW_AW'(N_ROWS - 1));
    assign o_wb_done  = out_fire & o_out_last;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            res_mem[wr_cnt_q[ROW_AW-1:0]] <= wr_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt_q    <= '0;
            rd_ptr_q    <= '0;
            o_out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end
            if (buf_full && !o_out_valid) begin
                o_out_valid <= 1'b1;
            end
            if (out_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (o_wb_done) begin                      // tile drained, rearm.
                wr_cnt_q    <= '0;
                rd_ptr_q    <= '0;
                o_out_valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/bs_mac_core.sv
`timescale 1ns/1ps

module bs_mac_core (
    input  logic               clk,
    input  logic               rst_n,
    exec_if.bs                 ex,
    output accel_pkg::acc_t    o_sum,
    output logic               o_sum_valid
);
    import accel_pkg::*;

    localparam int PLANE_W = $clog2(ELEM_W);

    logic [PLANE_W-1:0] plane_q;                      // current activation bit plane.
    logic [LANES-1:0]   act_bit;
    elem_t              wgt_lane [LANES];
    acc_t               plane_sum;
    acc_t               plane_term;
    acc_t               acc_base;
    acc_t               acc_next;
    acc_t               acc_q;
    logic               sign_plane;

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign act_bit[g]  = ex.act[g*ELEM_W + plane_q];
        assign wgt_lane[g] = ex.wgt[g*ELEM_W +: ELEM_W];
    end

    assign sign_plane = (plane_q == PLANE_W'(ELEM_W - 1));

    // ****************************************************************
    // one bit plane per cycle
    // ****************************************************************
    always_comb begin
        plane_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            if (act_bit[i]) begin
                plane_sum = plane_sum + wgt_lane[i];
            end
        end
        plane_term = plane_sum <<< plane_q;
        acc_base   = (ex.first && plane_q == '0) ? '0 : acc_q;
        // msb plane carries negative weight in two's complement.
        acc_next   = sign_plane ? acc_base - plane_term : acc_base + plane_term;
    end

    assign ex.ack_bs = ex.valid_bs & sign_plane;

    always_ff @(posedge clk) begin
        if (ex.valid_bs) begin
            acc_q <= acc_next;
        end
        if (ex.ack_bs && ex.last) begin
            o_sum <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plane_q     <= '0;
            o_sum_valid <= 1'b0;
        end else begin
            o_sum_valid <= ex.ack_bs & ex.last;
            if (ex.valid_bs) begin
                plane_q <= plane_q + 1'b1;            // wraps to 0 after the ack.
            end
        end
    end

endmodule

// File: source/bp_mac_core.sv
`timescale 1ns/1ps

module bp_mac_core (
    input  logic               clk,
    input  logic               rst_n,
    exec_if.bp                 ex,
    output accel_pkg::acc_t    o_sum,
    output logic               o_sum_valid
);
    import accel_pkg::*;

    logic signed [2*ELEM_W-1:0] prod [LANES];
    acc_t                       dot;
    acc_t                       acc_q;
    acc_t                       acc_next;

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign prod[g] = elem_t'(ex.act[g*ELEM_W +: ELEM_W]) *
                         elem_t'(ex.wgt[g*ELEM_W +: ELEM_W]);
    end

    always_comb begin
        dot = '0;
        for (int i = 0; i < LANES; i++) begin
            dot = dot + prod[i];                      // sign-extended lane products.
        end
        acc_next = (ex.first ? '0 : acc_q) + dot;
    end

    assign ex.ack_bp = ex.valid_bp;                   // one word per cycle.

    always_ff @(posedge clk) begin
        if (ex.valid_bp) begin
            acc_q <= acc_next;
        end
        if (ex.valid_bp && ex.last) begin
            o_sum <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_sum_valid <= 1'b0;
        end else begin
            o_sum_valid <= ex.ack_bp & ex.last;
        end
    end

endmodule

// File: source/operand_buf.sv
`timescale 1ns/1ps

module operand_buf #(
    parameter  int N_ROWS  = 4,
    parameter  int MAX_LEN = 16,
    localparam int ACT_AW  = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
    localparam int WGT_AW  = (N_ROWS * MAX_LEN > 1) ? $clog2(N_ROWS * MAX_LEN) : 1
) (
    input  logic                 clk,
    input  logic                 i_act_we,
    input  logic                 i_wgt_we,
    input  logic [WGT_AW-1:0]    i_ld_addr,
    input  accel_pkg::word_t     i_act_data,
    input  accel_pkg::word_t     i_wgt_data,
    input  logic [ACT_AW-1:0]    i_ex_act_addr,
    input  logic [WGT_AW-1:0]    i_ex_wgt_addr,
    exec_if.obuf                 ex
);
    import accel_pkg::*;

    word_t act_mem [MAX_LEN];                         // one activation vector.
    word_t wgt_mem [N_ROWS * MAX_LEN];                // row-major weight matrix.

    always_ff @(posedge clk) begin
        if (i_act_we) begin
            act_mem[i_ld_addr[ACT_AW-1:0]] <= i_act_data;
        end
        if (i_wgt_we) begin
            wgt_mem[i_ld_addr] <= i_wgt_data;
        end
    end

    // combinational read, the cores see the pair in the same cycle.
    assign ex.act = act_mem[i_ex_act_addr];
    assign ex.wgt = wgt_mem[i_ex_wgt_addr];

endmodule

// File: source/glb_ctrl.sv
`timescale 1ns/1ps

module glb_ctrl #(
    parameter  int N_ROWS  = 4,
    parameter  int MAX_LEN = 16,
    localparam int ACT_AW  = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1,
    localparam int WGT_AW  = (N_ROWS * MAX_LEN > 1) ? $clog2(N_ROWS * MAX_LEN) : 1,
    localparam int ROW_AW  = (N_ROWS > 1) ? $clog2(N_ROWS) : 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_instr_valid,
    output logic                 o_instr_ready,
    input  accel_pkg::instr_t    i_instr_data,
    input  logic                 i_act_valid,
    output logic                 o_act_ready,
    input  logic                 i_wgt_valid,
    output logic                 o_wgt_ready,
    output logic                 o_act_we,
    output logic                 o_wgt_we,
    output logic [WGT_AW-1:0]    o_ld_addr,
    output logic [ACT_AW-1:0]    o_ex_act_addr,
    output logic [WGT_AW-1:0]    o_ex_wgt_addr,
    input  logic                 i_wb_done,
    exec_if.ctrl                 ex
);
    import accel_pkg::*;

    ctrl_state_e        state_q;
    logic [ACT_AW-1:0]  len_m1_q;
    logic               core_sel_q;
    logic [WGT_AW-1:0]  addr_q;                       // load address, then weight read address.
    logic [ACT_AW-1:0]  word_q;
    logic [ROW_AW-1:0]  row_q;
    logic [WGT_AW-1:0]  wgt_last;
    logic               word_last;
    logic               ack;

    assign o_instr_ready = (state_q == IDLE);
    assign o_act_ready   = (state_q == LOAD_ACT);
    assign o_wgt_ready   = (state_q == LOAD_WGT);
    assign o_act_we      = o_act_ready & i_act_valid;
    assign o_wgt_we      = o_wgt_ready & i_wgt_valid;
    assign o_ld_addr     = addr_q;
    assign o_ex_act_addr = word_q;
    assign o_ex_wgt_addr = addr_q;                    // row-major, so row*len + word is linear.

    assign wgt_last  = WGT_AW'(N_ROWS * (int'(len_m1_q) + 1) - 1);
    assign word_last = (word_q == len_m1_q);

    assign ex.valid_bp = (state_q == EXEC) & ~core_sel_q;
    assign ex.valid_bs = (state_q == EXEC) & core_sel_q;
    assign ex.first    = (word_q == '0);
    assign ex.last     = word_last;
    assign ack         = core_sel_q ? ex.ack_bs : ex.ack_bp;

    // ****************************************************************
    // sequencing FSM
    // ****************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            len_m1_q   <= '0;
            core_sel_q <= 1'b0;
            addr_q     <= '0;
            word_q     <= '0;
            row_q      <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_instr_valid) begin
                        len_m1_q   <= ACT_AW'(i_instr_data[INSTR_LEN_LSB +: INSTR_LEN_W]);
                        core_sel_q <= i_instr_data[INSTR_SEL_BIT];
                        addr_q     <= '0;
                        state_q    <= LOAD_ACT;
                    end
                end
                LOAD_ACT: begin
                    if (o_act_we) begin
                        if (addr_q == WGT_AW'(len_m1_q)) begin
                            addr_q  <= '0;
                            state_q <= LOAD_WGT;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                LOAD_WGT: begin
                    if (o_wgt_we) begin
                        if (addr_q == wgt_last) begin
                            addr_q  <= '0;
                            word_q  <= '0;
                            row_q   <= '0;
                            state_q <= EXEC;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end
                end
                EXEC: begin
                    if (ack) begin                    // step only when the core takes the pair.
                        addr_q <= addr_q + 1'b1;
                        if (word_last) begin
                            word_q <= '0;
                            row_q  <= row_q + 1'b1;
                            if (row_q == ROW_AW'(N_ROWS - 1)) begin
                                state_q <= WAIT_WB;
                            end
                        end else begin
                            word_q <= word_q + 1'b1;
                        end
                    end
                end
                WAIT_WB: begin
                    if (i_wb_done) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// File: source/exec_if.sv
`timescale 1ns/1ps

interface exec_if;
    import accel_pkg::*;

    logic  valid_bp;                                  // word pair offered to bp core.
    logic  valid_bs;                                  // word pair offered to bs core.
    logic  first;                                     // first word of a row.
    logic  last;                                      // final word of a row.
    word_t act;
    word_t wgt;
    logic  ack_bp;
    logic  ack_bs;

    modport ctrl (output valid_bp, valid_bs, first, last, input ack_bp, ack_bs);

    // operand buffer side, read data only.
    modport obuf (output act, wgt);

    modport bp (input valid_bp, first, last, act, wgt, output ack_bp);

    modport bs (input valid_bs, first, last, act, wgt, output ack_bs);

endinterface

// File: source/accel_pkg.sv
package accel_pkg;

    // ****************************************************************
    // datapath widths
    // ****************************************************************
    localparam int WORD_W = 32;                       // data and instruction word.
    localparam int LANES  = 4;                        // int8 elements per word.
    localparam int ELEM_W = 8;

    typedef logic        [WORD_W-1:0] word_t;         // lane i at bits 8i+7..8i.
    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [WORD_W-1:0] acc_t;          // row sum and result beat.

    // ****************************************************************
    // instruction format
    // ****************************************************************
    typedef logic [WORD_W-1:0] instr_t;

    localparam int INSTR_LEN_LSB = 0;                 // len_m1, len = len_m1 + 1.
    localparam int INSTR_LEN_W   = 4;
    localparam int INSTR_SEL_BIT = 8;                 // 1 = bit-serial core.

    // ****************************************************************
    // controller states
    // ****************************************************************
    typedef enum logic [2:0] {
        IDLE,
        LOAD_ACT,
        LOAD_WGT,
        EXEC,
        WAIT_WB
    } ctrl_state_e;

endpackage
